// File: include/spn_macros.svh
`ifndef SPN_MACROS_SVH
`define SPN_MACROS_SVH

// S-box width, one field element
`define SPN_WORD_W 6

// Words per block
`define SPN_WORDS 4

// Block and key width
`define SPN_BLOCK_W (`SPN_WORD_W * `SPN_WORDS)

// Keyed rounds before the final whitening
`define SPN_ROUNDS 6

`endif

// File: design/gf_pkg.sv
`default_nettype none

`include "spn_macros.svh"

package gf_pkg;

  typedef logic [1:0] gf4_t;                 // Tower subfield element
  typedef logic [`SPN_WORD_W-1:0] gf64_t;    // Full field element

  // Coefficient c0 sits in the low bits
  typedef struct packed {
    gf4_t c2;
    gf4_t c1;
    gf4_t c0;
  } tower_t;

  function automatic gf4_t gf4_add(gf4_t a, gf4_t b);
    return a ^ b;
  endfunction

  function automatic gf4_t gf4_square(gf4_t a);
    gf4_t r;
    r[0] = a[0] ^ a[1];
    r[1] = a[1];
    return r;
  endfunction

  function automatic gf4_t gf4_mul(gf4_t a, gf4_t b);
    logic hi;
    gf4_t r;
    hi = a[1] & b[1];                        // Reduction term
    r[0] = (a[0] & b[0]) ^ hi;
    r[1] = (a[0] & b[1]) ^ (a[1] & b[0]) ^ hi;
    return r;
  endfunction

  // a^3 is 1 for any nonzero a, so this passes b when a is nonzero
  function automatic gf4_t gf4_cube_scale(gf4_t a, gf4_t b);
    logic nz;
    gf4_t r;
    nz = a[0] ^ (~a[0] & a[1]);
    r[0] = nz & b[0];
    r[1] = nz & b[1];
    return r;
  endfunction

endpackage

`default_nettype wire

// File: design/spn_pkg.sv
`default_nettype none

`include "spn_macros.svh"

package spn_pkg;

  typedef enum logic {
    op_load_key,
    op_encrypt
  } opcode_e;

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_done
  } state_e;

  // Word w0 is the low end of the block
  typedef struct packed {
    gf_pkg::gf64_t w3;
    gf_pkg::gf64_t w2;
    gf_pkg::gf64_t w1;
    gf_pkg::gf64_t w0;
  } block_t;

  typedef struct packed {
    opcode_e                 op;
    logic [`SPN_BLOCK_W-1:0] data;     // Plaintext or key
  } cmd_t;

endpackage

`default_nettype wire

// File: design/gf43_power13.sv
`timescale 1ns/1ns
`default_nettype none

module gf43_power13 (
  input  wire gf_pkg::gf64_t a,
  output gf_pkg::gf64_t      b
);

  gf_pkg::tower_t t_in;
  gf_pkg::tower_t t_out;
  gf_pkg::gf4_t   x0, x1, x2;
  gf_pkg::gf4_t   sq0, sq1, sq2;
  gf_pkg::gf4_t   cs01, cs02, cs10, cs12, cs20, cs21;
  gf_pkg::gf4_t   m01, m02, m12;
  gf_pkg::gf4_t   p01, p02, p12;
  gf_pkg::gf4_t   q0, q1, q2;

  assign t_in = a;
  assign x0   = t_in.c0;
  assign x1   = t_in.c1;
  assign x2   = t_in.c2;

  assign sq0 = gf_pkg::gf4_square(x0);
  assign sq1 = gf_pkg::gf4_square(x1);
  assign sq2 = gf_pkg::gf4_square(x2);

  // Cross terms scaled by the cube of the first operand
  assign cs01 = gf_pkg::gf4_cube_scale(x0, x1);
  assign cs02 = gf_pkg::gf4_cube_scale(x0, x2);
  assign cs10 = gf_pkg::gf4_cube_scale(x1, x0);
  assign cs12 = gf_pkg::gf4_cube_scale(x1, x2);
  assign cs20 = gf_pkg::gf4_cube_scale(x2, x0);
  assign cs21 = gf_pkg::gf4_cube_scale(x2, x1);

  assign p01 = gf_pkg::gf4_mul(sq0, sq1);       // Products of squares
  assign p02 = gf_pkg::gf4_mul(sq0, sq2);
  assign p12 = gf_pkg::gf4_mul(sq1, sq2);

  assign m12 = gf_pkg::gf4_mul(x1, x2);
  assign m02 = gf_pkg::gf4_mul(x0, x2);
  assign m01 = gf_pkg::gf4_mul(x0, x1);

  assign q0 = gf_pkg::gf4_mul(sq0, m12);        // Square times the other pair
  assign q1 = gf_pkg::gf4_mul(sq1, m02);
  assign q2 = gf_pkg::gf4_mul(sq2, m01);

  assign t_out.c0 = gf_pkg::gf4_add(
                      gf_pkg::gf4_add(gf_pkg::gf4_add(x0, x1), gf_pkg::gf4_add(cs10, cs12)),
                      gf_pkg::gf4_add(gf_pkg::gf4_add(cs20, p01),
                                      gf_pkg::gf4_add(p02, gf_pkg::gf4_add(q0, q2))));

  assign t_out.c1 = gf_pkg::gf4_add(
                      gf_pkg::gf4_add(gf_pkg::gf4_add(x1, x2), gf_pkg::gf4_add(cs01, cs20)),
                      gf_pkg::gf4_add(gf_pkg::gf4_add(cs21, p01),
                                      gf_pkg::gf4_add(p12, gf_pkg::gf4_add(q0, q1))));

  assign t_out.c2 = gf_pkg::gf4_add(
                      gf_pkg::gf4_add(gf_pkg::gf4_add(x0, x2), gf_pkg::gf4_add(cs01, cs02)),
                      gf_pkg::gf4_add(gf_pkg::gf4_add(cs12, p02),
                                      gf_pkg::gf4_add(p12, gf_pkg::gf4_add(q1, q2))));

  assign b = t_out;

endmodule

`default_nettype wire

// File: design/sbox6.sv
`timescale 1ns/1ns
`default_nettype none

module sbox6 (
  input  wire gf_pkg::gf64_t x,
  output gf_pkg::gf64_t      y
);

  gf_pkg::gf64_t z;     // Tower basis input
  gf_pkg::gf64_t w;     // Tower basis power
  gf_pkg::gf64_t p;     // Back in the polynomial basis
  logic          lin;

  // Polynomial basis into tower basis
  assign z[0] = x[0] ^ x[1] ^ x[2] ^ x[5];
  assign z[1] = x[1] ^ x[2] ^ x[3] ^ x[5];
  assign z[2] = x[0] ^ x[2] ^ x[4] ^ x[5];
  assign z[3] = x[1] ^ x[2] ^ x[4] ^ x[5];
  assign z[4] = x[0] ^ x[5];
  assign z[5] = x[4];

  gf43_power13 i_power13 (
    .a (z),
    .b (w)
  );

  assign p[0] = w[2] ^ w[4];
  assign p[1] = w[1] ^ w[2] ^ w[4];
  assign p[2] = w[0];
  assign p[3] = w[3] ^ w[4];
  assign p[4] = w[0] ^ w[1] ^ w[4] ^ w[5];
  assign p[5] = w[0] ^ w[1] ^ w[3] ^ w[4];

  // Affine step uses the raw input, not the power
  assign lin = x[2] ^ x[4];
  assign y   = p ^ {$bits(gf_pkg::gf64_t){lin}};

endmodule

`default_nettype wire

// File: design/spn_round.sv
`timescale 1ns/1ns
`default_nettype none

`include "spn_macros.svh"

module spn_round (
  input  wire spn_pkg::block_t state_in,
  input  wire spn_pkg::block_t round_key,
  output spn_pkg::block_t      state_out
);

  wire [`SPN_BLOCK_W-1:0] mixed;
  wire [`SPN_BLOCK_W-1:0] sub;
  wire [`SPN_BLOCK_W-1:0] perm;

  assign mixed = state_in ^ round_key;   // Key addition

  for (genvar i = 0; i < `SPN_WORDS; i++) begin : g_sbox
    sbox6 i_sbox (
      .x (mixed[i*`SPN_WORD_W +: `SPN_WORD_W]),
      .y (sub[i*`SPN_WORD_W +: `SPN_WORD_W])
    );
  end

  // Bit i of a word lands in word (i mod 4), so each word feeds all four
  for (genvar i = 0; i < `SPN_BLOCK_W; i++) begin : g_perm
    assign perm[`SPN_WORD_W*(i % `SPN_WORDS) + i/`SPN_WORDS] = sub[i];
  end

  assign state_out = perm;

endmodule

`default_nettype wire

// File: design/key_schedule.sv
`timescale 1ns/1ns
`default_nettype none

`include "spn_macros.svh"

module key_schedule (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            key_we,
  input  wire spn_pkg::block_t key_in,
  input  wire logic [2:0]      round_idx,
  output spn_pkg::block_t      round_key
);

  spn_pkg::block_t          key_q;
  logic [2*`SPN_BLOCK_W-1:0] key_dbl;
  logic [`SPN_BLOCK_W-1:0]   rot;
  gf_pkg::gf64_t            sub_word;
  gf_pkg::gf64_t            rc;

  // Stored master key
  always_ff @(posedge clk) begin
    if (reset) begin
      key_q <= '0;
    end else if (key_we) begin
      key_q <= key_in;
    end
  end

  assign key_dbl = {key_q, key_q};

  // Left rotate by whole words, modulo the block
  always_comb begin
    int unsigned shift;
    shift = `SPN_WORD_W * (round_idx % `SPN_WORDS);
    rot   = key_dbl[2*`SPN_BLOCK_W-1-shift -: `SPN_BLOCK_W];
  end

  sbox6 i_sbox (
    .x (rot[`SPN_WORD_W-1:0]),
    .y (sub_word)
  );

  assign rc = {{(`SPN_WORD_W-3){1'b0}}, round_idx};   // Round constant

  assign round_key = (round_idx == 3'd0) ? key_q
                                         : {rot[`SPN_BLOCK_W-1:`SPN_WORD_W], sub_word ^ rc};

endmodule

`default_nettype wire

// File: design/spn_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "spn_macros.svh"

module spn_core (
  input  wire logic          clk,
  input  wire logic          reset,
  input  wire logic          start,
  input  wire spn_pkg::cmd_t cmd,
  output logic               busy,
  output logic               done,
  output spn_pkg::block_t    result,
  output logic               key_loaded
);

  spn_pkg::state_e fsm_q;
  spn_pkg::block_t state_q;
  spn_pkg::block_t round_out;
  spn_pkg::block_t round_key;
  spn_pkg::block_t whitened;
  spn_pkg::block_t result_q;
  logic [2:0]      round_idx;
  logic            accept;
  logic            key_we;
  logic            enc_go;

  assign busy   = (fsm_q == spn_pkg::st_run);
  assign done   = (fsm_q == spn_pkg::st_done);
  assign accept = start & ~busy;                      // Starts while busy are dropped
  assign key_we = accept & (cmd.op == spn_pkg::op_load_key);
  assign enc_go = accept & (cmd.op == spn_pkg::op_encrypt);

  // Round index sits at SPN_ROUNDS in st_done, selecting the whitening key
  assign whitened = state_q ^ round_key;
  assign result   = done ? whitened : result_q;

  spn_round i_round (
    .state_in  (state_q),
    .round_key (round_key),
    .state_out (round_out)
  );

  key_schedule i_key_schedule (
    .clk       (clk),
    .reset     (reset),
    .key_we    (key_we),
    .key_in    (cmd.data),
    .round_idx (round_idx),
    .round_key (round_key)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      fsm_q      <= spn_pkg::st_idle;
      round_idx  <= '0;
      key_loaded <= 1'b0;
      result_q   <= '0;
    end else begin
      if (key_we) begin
        key_loaded <= 1'b1;
      end
      if (done) begin
        result_q <= whitened;                         // Held until the next done
      end
      case (fsm_q)
        spn_pkg::st_run: begin
          round_idx <= round_idx + 3'd1;
          if (round_idx == 3'(`SPN_ROUNDS - 1)) begin
            fsm_q <= spn_pkg::st_done;
          end
        end
        default: begin                                // Idle and done accept a start
          if (enc_go) begin
            fsm_q     <= spn_pkg::st_run;
            round_idx <= '0;
          end else begin
            fsm_q <= spn_pkg::st_idle;
          end
        end
      endcase
    end
  end

  // Block state
  always_ff @(posedge clk) begin
    if (enc_go) begin
      state_q <= cmd.data;
    end else if (busy) begin
      state_q <= round_out;
    end
  end

endmodule

`default_nettype wire

// File: sim/spn_core_sva.sv
`timescale 1ns/1ns
`default_nettype none

module spn_core_sva (
  input wire logic            clk,
  input wire logic            reset,
  input wire logic            start,
  input wire spn_pkg::cmd_t   cmd,
  input wire logic            busy,
  input wire logic            done,
  input wire spn_pkg::block_t result,
  input wire logic            key_loaded
);

  int unsigned fail_count = 0;
  logic        enc_accept;
  logic        key_accept;

  assign enc_accept = start && !busy && (cmd.op == spn_pkg::op_encrypt);
  assign key_accept = start && !busy && (cmd.op == spn_pkg::op_load_key);

  // Six round cycles, then the done cycle
  a_enc_timing: assert property (@(posedge clk) disable iff (reset)
    enc_accept |=> busy [*6] ##1 (done && !busy))
    else begin
      fail_count++;
      $error("encrypt start not followed by six busy cycles and one done");
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else begin
      fail_count++;
      $error("done held high for more than one cycle");
    end

  a_key_load: assert property (@(posedge clk) disable iff (reset)
    key_accept |=> key_loaded && !busy)
    else begin
      fail_count++;
      $error("key load did not set key_loaded or raised busy");
    end

  // Only a done cycle may show a new result
  a_result_hold: assert property (@(posedge clk) disable iff (reset)
    !done |-> $stable(result))
    else begin
      fail_count++;
      $error("result changed outside a done cycle");
    end

endmodule

bind spn_core spn_core_sva i_sva (.*);

`default_nettype wire

// File: sim/tb_spn_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "spn_macros.svh"

module tb_spn_core;

  typedef logic [`SPN_BLOCK_W-1:0] blk_t;

  localparam int TIMEOUT = 20;
  // Isomorphism rows, row k in bits 6k+5..6k, as input bit masks
  localparam logic [35:0] FWD = {6'b010000, 6'b100001, 6'b110110,
                                 6'b110101, 6'b101110, 6'b100111};
  localparam logic [35:0] INV = {6'b011011, 6'b110011, 6'b011000,
                                 6'b000001, 6'b010110, 6'b010100};

  logic            clk;
  logic            reset;
  logic            start;
  spn_pkg::cmd_t   cmd;
  logic            busy;
  logic            done;
  spn_pkg::block_t result;
  logic            key_loaded;

  integer seed = 94;
  int     errors = 0;
  int     passed = 0;
  int     failed = 0;
  blk_t   key_m = '0;        // Key the model assumes is stored

  spn_core i_dut (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .cmd        (cmd),
    .busy       (busy),
    .done       (done),
    .result     (result),
    .key_loaded (key_loaded)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic gf_pkg::gf64_t mat_mul(logic [35:0] rows, gf_pkg::gf64_t v);
    gf_pkg::gf64_t r;
    for (int k = 0; k < 6; k++) begin
      r[k] = ^(rows[6*k +: 6] & v);
    end
    return r;
  endfunction

  function automatic gf_pkg::gf64_t pow13_ref(gf_pkg::gf64_t v);
    gf_pkg::tower_t t;
    gf_pkg::gf4_t   x0, x1, x2, s0, s1, s2;
    gf_pkg::gf4_t   p01, p02, p12, q0, q1, q2;
    t   = v;
    x0  = t.c0;
    x1  = t.c1;
    x2  = t.c2;
    s0  = gf_pkg::gf4_square(x0);
    s1  = gf_pkg::gf4_square(x1);
    s2  = gf_pkg::gf4_square(x2);
    p01 = gf_pkg::gf4_mul(s0, s1);
    p02 = gf_pkg::gf4_mul(s0, s2);
    p12 = gf_pkg::gf4_mul(s1, s2);
    q0  = gf_pkg::gf4_mul(s0, gf_pkg::gf4_mul(x1, x2));
    q1  = gf_pkg::gf4_mul(s1, gf_pkg::gf4_mul(x0, x2));
    q2  = gf_pkg::gf4_mul(s2, gf_pkg::gf4_mul(x0, x1));
    t.c0 = x0 ^ x1 ^ gf_pkg::gf4_cube_scale(x1, x0) ^ gf_pkg::gf4_cube_scale(x1, x2)
           ^ gf_pkg::gf4_cube_scale(x2, x0) ^ p01 ^ p02 ^ q0 ^ q2;
    t.c1 = x1 ^ x2 ^ gf_pkg::gf4_cube_scale(x0, x1) ^ gf_pkg::gf4_cube_scale(x2, x0)
           ^ gf_pkg::gf4_cube_scale(x2, x1) ^ p01 ^ p12 ^ q0 ^ q1;
    t.c2 = x0 ^ x2 ^ gf_pkg::gf4_cube_scale(x0, x1) ^ gf_pkg::gf4_cube_scale(x0, x2)
           ^ gf_pkg::gf4_cube_scale(x1, x2) ^ p02 ^ p12 ^ q1 ^ q2;
    return t;
  endfunction

  function automatic gf_pkg::gf64_t sbox_ref(gf_pkg::gf64_t v);
    gf_pkg::gf64_t p;
    p = mat_mul(INV, pow13_ref(mat_mul(FWD, v)));
    return p ^ {6{v[2] ^ v[4]}};      // Affine step
  endfunction

  function automatic blk_t round_key_ref(blk_t k, int r);
    blk_t rot;
    rot = k;
    for (int i = 0; i < r; i++) begin
      rot = {rot[`SPN_BLOCK_W-7:0], rot[`SPN_BLOCK_W-1 -: 6]};
    end
    if (r != 0) begin
      rot[5:0] = sbox_ref(rot[5:0]) ^ gf_pkg::gf64_t'(r);
    end
    return rot;
  endfunction

  function automatic blk_t round_ref(blk_t s, blk_t rk);
    blk_t m;
    blk_t o;
    m = s ^ rk;
    for (int w = 0; w < `SPN_WORDS; w++) begin
      m[6*w +: 6] = sbox_ref(m[6*w +: 6]);
    end
    for (int i = 0; i < `SPN_BLOCK_W; i++) begin
      o[6*(i % 4) + i/4] = m[i];
    end
    return o;
  endfunction

  function automatic blk_t encrypt_ref(blk_t k, blk_t pt);
    blk_t s;
    s = pt;
    for (int r = 0; r < `SPN_ROUNDS; r++) begin
      s = round_ref(s, round_key_ref(k, r));
    end
    return s ^ round_key_ref(k, `SPN_ROUNDS);
  endfunction

  function automatic blk_t rand_block();
    logic [31:0] v;
    v = $random(seed);
    return v[`SPN_BLOCK_W-1:0];
  endfunction

  task automatic check_value(string what, blk_t got, blk_t exp);
    assert (got === exp) else begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic issue(spn_pkg::opcode_e op, blk_t data);
    start    <= 1'b1;
    cmd.op   <= op;
    cmd.data <= data;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic load_key(blk_t k);
    issue(spn_pkg::op_load_key, k);
    key_m = k;
  endtask

  task automatic wait_done(output int latency, output int busy_cycles);
    latency     = 0;
    busy_cycles = 0;
    do begin
      @(posedge clk);
      latency++;
      if (busy) busy_cycles++;
    end while (!done && latency < TIMEOUT);
    if (!done) begin
      $display("Timeout: no done pulse within %0d cycles", TIMEOUT);
      $display("Testbench failed");
      $finish;
    end
  endtask

  task automatic run_encrypt(blk_t pt, string what);
    int lat;
    int bcy;
    issue(spn_pkg::op_encrypt, pt);
    wait_done(lat, bcy);
    check_value({what, " result"}, result, encrypt_ref(key_m, pt));
    check_value({what, " latency"}, lat, 7);
    check_value({what, " busy cycles"}, bcy, 6);
  endtask

  task automatic end_test(string name, int errors_before);
    if (errors == errors_before) begin
      passed++;
      $display("test %-12s ok", name);
    end else begin
      failed++;
      $display("test %-12s failed", name);
    end
  endtask

  initial begin
    int   e0;
    int   lat;
    int   bcy;
    blk_t pt;
    blk_t held;
    reset = 1'b1;
    start = 1'b0;
    cmd   = '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    e0 = errors;
    check_value("reset busy", busy, 0);
    check_value("reset done", done, 0);
    check_value("reset key_loaded", key_loaded, 0);
    check_value("reset result", result, 0);
    run_encrypt(rand_block(), "no key");        // All-zero key before any load
    load_key(rand_block());
    repeat (3) begin
      @(posedge clk);
      check_value("load busy", busy, 0);
      check_value("load done", done, 0);
      check_value("load key_loaded", key_loaded, 1);
    end
    end_test("reset_load", e0);

    e0 = errors;
    run_encrypt(rand_block(), "timing");
    end_test("timing", e0);

    e0 = errors;
    for (int n = 0; n < 40; n++) begin
      load_key(rand_block());
      run_encrypt(rand_block(), "random");
    end
    end_test("random", e0);

    e0 = errors;
    load_key(rand_block());
    pt = rand_block();
    issue(spn_pkg::op_encrypt, pt);
    issue(spn_pkg::op_load_key, ~key_m);        // Both dropped while busy
    issue(spn_pkg::op_encrypt, ~pt);
    wait_done(lat, bcy);
    check_value("busy start result", result, encrypt_ref(key_m, pt));
    repeat (10) begin
      @(posedge clk);
      check_value("extra done", done, 0);
    end
    run_encrypt(pt, "key kept");
    end_test("busy_start", e0);

    e0 = errors;
    load_key('0);
    run_encrypt('0, "zero");
    end_test("zero", e0);

    e0 = errors;
    run_encrypt(rand_block(), "hold");
    held = result;
    repeat (5) begin
      @(posedge clk);
      check_value("held result", result, held);
    end
    load_key(rand_block());
    repeat (3) begin
      @(posedge clk);
      check_value("held result after load", result, held);
    end
    end_test("hold", e0);

    $display("tests passed %0d, failed %0d, assertion failures %0d",
             passed, failed, i_dut.i_sva.fail_count);
    if (failed == 0 && i_dut.i_sva.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
design/gf_pkg.sv
design/spn_pkg.sv
design/gf43_power13.sv
design/sbox6.sv
design/spn_round.sv
design/key_schedule.sv
design/spn_core.sv
sim/spn_core_sva.sv
sim/tb_spn_core.sv

// File: Bender.yml
package:
  name: spn_engine

export_include_dirs:
  - include

sources:
  - files:
      - design/gf_pkg.sv
      - design/spn_pkg.sv
      - design/gf43_power13.sv
      - design/sbox6.sv
      - design/spn_round.sv
      - design/key_schedule.sv
      - design/spn_core.sv
  - target: simulation
    files:
      - sim/spn_core_sva.sv
      - sim/tb_spn_core.sv
